/* rtl/cart_defines.svh */
// Cartridge loader macros for download widths, header offsets, cheat index, gun delay
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

////////////////////////////////////////
// Download stream widths
////////////////////////////////////////

`define CART_ADDR_W 25 // Byte address
`define CART_DATA_W 16 // One download word

// Index reserved for cheat code files
`define CART_CHEAT_INDEX 8'hFF

////////////////////////////////////////
// Cartridge header offsets
////////////////////////////////////////

// Region letters
`define CART_HDR_REGION0 25'h1F0
`define CART_HDR_REGION1 25'h1F2

// First word past the header
`define CART_HDR_END 25'h200

// Product identifier, eight characters over five words
`define CART_ID_FIRST 25'h182
`define CART_ID_LAST  25'h18A
`define CART_ID_CHECK 25'h18C // Identifier complete here

////////////////////////////////////////
// Light gun
////////////////////////////////////////

`define CART_GUN_DELAY_DEFAULT 8'd44 // Sensor delay for most titles

`endif

/* rtl/bus_pkg.sv */
// Package with APB request and response structs for the ROM storage bus
`default_nettype none

`include "cart_defines.svh"

package bus_pkg;

	////////////////////////////////////////
	// ROM storage APB
	////////////////////////////////////////

	// Requester to completer
	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [`CART_ADDR_W-2:0]  paddr;  // Word address
		logic [`CART_DATA_W-1:0]  pwdata;
		logic [1:0]               pstrb;  // One strobe per byte
	} rom_apb_req_t;

	// Completer to requester
	typedef struct packed {
		logic                     pready;
		logic [`CART_DATA_W-1:0]  prdata;
	} rom_apb_rsp_t;

	// No pslverr here, storage never errors

endpackage

`default_nettype wire

/* rtl/cart_pkg.sv */
// Package with region, quirk, light gun, cheat code and download beat types
`default_nettype none

`include "cart_defines.svh"

package cart_pkg;

	////////////////////////////////////////
	// Console setup from the header
	////////////////////////////////////////

	// Region request, same coding as the console menu
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Compatibility quirks
	typedef struct packed {
		logic sram;   // Forced SRAM mapping
		logic eeprom; // Serial EEPROM save
		logic noram;  // No backup RAM
		logic fifo;   // Fast VDP FIFO
		logic svp;    // SVP chip present
		logic fmbusy; // FM busy flag emulation
	} cart_quirks_t;

	typedef struct packed {
		logic       gun_type;     // 0 Menacer, 1 Justifier
		logic [7:0] sensor_delay;
	} gun_cfg_t;

	////////////////////////////////////////
	// Cheats and download beats
	////////////////////////////////////////

	// One code, big endian fields as the host sends them
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Decoded download beat
	typedef struct packed {
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
		logic                    wr;
	} dl_word_t;

endpackage

`default_nettype wire

/* rtl/cart_header_scan.sv */
// Header scanner for region letters, product identifier, quirks, gun setup and region choice
`default_nettype none

`include "cart_defines.svh"

module cart_header_scan (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     dl_active,
	input  wire  [7:0]              dl_index,
	input  wire  cart_pkg::dl_word_t rom_beat,
	input  wire                     region_auto_off,
	input  wire                     region_from_ext,
	input  wire  [1:0]              region_priority,
	output cart_pkg::region_t       region_req,
	output logic                    region_set,
	output cart_pkg::cart_quirks_t  quirks,
	output cart_pkg::gun_cfg_t      gun_cfg
);

	logic        dl_active_q;
	logic        hdr_j, hdr_u, hdr_e;
	logic [63:0] cart_id;      // Eight ASCII characters
	logic [7:0]  lo, hi;
	logic [3:0]  hrgn;         // Hex letter A..F as a value

	assign lo   = rom_beat.data[7:0];
	assign hi   = rom_beat.data[15:8];
	assign hrgn = lo[3:0] - 4'd7;

	// Region from flags, first match in priority order wins
	function automatic cart_pkg::region_t pick_region(input logic j, input logic u,
		input logic e, input logic [1:0] prio);
		cart_pkg::region_t r;
		case (prio)
			2'd0: r = u ? cart_pkg::US : e ? cart_pkg::EU : j ? cart_pkg::JP : cart_pkg::US;
			2'd1: r = e ? cart_pkg::EU : u ? cart_pkg::US : j ? cart_pkg::JP : cart_pkg::EU;
			2'd2: r = u ? cart_pkg::US : j ? cart_pkg::JP : e ? cart_pkg::EU : cart_pkg::US;
			default: r = j ? cart_pkg::JP : u ? cart_pkg::US : e ? cart_pkg::EU : cart_pkg::JP;
		endcase
		return r;
	endfunction

	function automatic cart_pkg::cart_quirks_t id_quirks(input logic [63:0] id);
		cart_pkg::cart_quirks_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ": q.sram   = 1'b1;
			"MK-1215 ", "G-4060  ": q.eeprom = 1'b1;
			"T-113016":             q.noram  = 1'b1; // Fake RAM check
			"T-89016 ":             q.fifo   = 1'b1;
			"MK-1229 ":             q.svp    = 1'b1;
			"T-35036 ":             q.fmbusy = 1'b1;
			default:                q = '0;
		endcase
		return q;
	endfunction

	function automatic cart_pkg::gun_cfg_t id_gun(input logic [63:0] id);
		cart_pkg::gun_cfg_t g;
		case (id)
			"T-95096-": g = '{gun_type: 1'b1, sensor_delay: 8'd52};
			"MK-1533 ": g = '{gun_type: 1'b0, sensor_delay: 8'd100};
			default:    g = '{gun_type: 1'b0, sensor_delay: `CART_GUN_DELAY_DEFAULT};
		endcase
		return g;
	endfunction

	////////////////////////////////////////
	// Identifier assembly
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rom_beat.wr) begin
			case (rom_beat.addr)
				`CART_ID_FIRST:        cart_id[63:56] <= hi;
				`CART_ID_FIRST + 25'd2: cart_id[55:40] <= {lo, hi};
				`CART_ID_FIRST + 25'd4: cart_id[39:24] <= {lo, hi};
				`CART_ID_FIRST + 25'd6: cart_id[23:8]  <= {lo, hi};
				`CART_ID_LAST:         cart_id[7:0]   <= lo;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Flags, quirks and region request
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_q <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			quirks      <= '0;
			gun_cfg     <= '{gun_type: 1'b0, sensor_delay: `CART_GUN_DELAY_DEFAULT};
			region_set  <= 1'b0;
			region_req  <= cart_pkg::JP;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active && !dl_active_q) begin // New download
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
				quirks <= '0;
			end
			if (!dl_active && dl_active_q)
				region_set <= 1'b0;

			if (rom_beat.wr) begin
				if (rom_beat.addr == `CART_HDR_REGION0) begin
					if (lo == "J") hdr_j <= 1'b1;
					else if (lo == "U") hdr_u <= 1'b1;
					else if (lo == "E") hdr_e <= 1'b1;
					else if (lo >= "0" && lo <= "9") {hdr_e, hdr_u, hdr_j} <= {lo[3], lo[2], lo[0]};
					else if (lo >= "A" && lo <= "F") {hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};
					// Some headers put the letter in the high byte
					if (hi == "J") hdr_j <= 1'b1;
					else if (hi == "U") hdr_u <= 1'b1;
					else if (hi == "E") hdr_e <= 1'b1;
				end
				if (rom_beat.addr == `CART_HDR_REGION1) begin
					if (lo == "J") hdr_j <= 1'b1;
					else if (lo == "U") hdr_u <= 1'b1;
					else if (lo == "E") hdr_e <= 1'b1;
				end
				if (rom_beat.addr == `CART_ID_CHECK) begin
					quirks  <= id_quirks(cart_id);
					gun_cfg <= id_gun(cart_id);
				end
				if (rom_beat.addr == `CART_HDR_END && !region_auto_off) begin
					if (region_from_ext) begin // Region coded in the file extension index
						region_set <= |dl_index;
						region_req <= cart_pkg::region_t'(dl_index[7:6]);
					end else begin
						region_set <= 1'b1;
						region_req <= pick_region(hdr_j, hdr_u, hdr_e, region_priority);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/cheat_code_loader.sv */
// Cheat code loader that assembles one code from eight download words
`default_nettype none

module cheat_code_loader (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire  cart_pkg::dl_word_t  cheat_beat,
	output cart_pkg::cheat_code_t     cheat_code,
	output logic                      cheat_valid
);

	logic last_word; // Replace high half closes a code

	assign last_word = cheat_beat.wr && (cheat_beat.addr[3:0] == 4'd14);

	////////////////////////////////////////
	// Word placement by offset
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cheat_beat.wr) begin
			case (cheat_beat.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= cheat_beat.data;
				4'd2:  cheat_code.flags[31:16]   <= cheat_beat.data;
				4'd4:  cheat_code.address[15:0]  <= cheat_beat.data;
				4'd6:  cheat_code.address[31:16] <= cheat_beat.data;
				4'd8:  cheat_code.compare[15:0]  <= cheat_beat.data;
				4'd10: cheat_code.compare[31:16] <= cheat_beat.data;
				4'd12: cheat_code.replace[15:0]  <= cheat_beat.data;
				4'd14: cheat_code.replace[31:16] <= cheat_beat.data;
				default: ; // Odd offsets never come from a 16 bit stream
			endcase
		end
	end

	// One pulse per complete code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= last_word;
	end

endmodule

`default_nettype wire

/* rtl/rom_download_writer.sv */
// ROM download writer with APB write, host back-pressure and ROM size capture
`default_nettype none

`include "cart_defines.svh"

module rom_download_writer (
	input  wire                      clk_sys,
	input  wire                      RESET,
	input  wire                      dl_active,
	input  wire  cart_pkg::dl_word_t rom_beat,
	output logic                     dl_wait,
	output logic [`CART_ADDR_W-1:0]  rom_size,
	output bus_pkg::rom_apb_req_t    apb_req,
	input  wire  bus_pkg::rom_apb_rsp_t apb_rsp
);

	logic                    psel_q, penable_q;
	logic [`CART_ADDR_W-2:0] paddr_q;
	logic [`CART_DATA_W-1:0] pwdata_q;
	logic                    dl_active_q;

	////////////////////////////////////////
	// APB write sequencer
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			psel_q      <= 1'b0;
			penable_q   <= 1'b0;
			dl_active_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (rom_beat.wr) begin // Setup next cycle
				psel_q    <= 1'b1;
				penable_q <= 1'b0;
			end else if (psel_q && !penable_q) begin
				penable_q <= 1'b1;
			end else if (penable_q && apb_rsp.pready) begin
				psel_q    <= 1'b0;
				penable_q <= 1'b0;
			end
		end
	end

	// Word address and byte swapped data, storage is little endian
	always_ff @(posedge clk_sys) begin
		if (rom_beat.wr) begin
			paddr_q  <= rom_beat.addr[`CART_ADDR_W-1:1];
			pwdata_q <= {rom_beat.data[7:0], rom_beat.data[15:8]};
		end
		if (dl_active_q && !dl_active)
			rom_size <= rom_beat.addr; // Last byte address of the image
	end

	assign dl_wait = psel_q; // Host held for the whole transfer
	assign apb_req = '{psel: psel_q, penable: penable_q, pwrite: 1'b1,
		paddr: paddr_q, pwdata: pwdata_q, pstrb: 2'b11};

	// Host must honour dl_wait, otherwise a word is dropped
	a_no_beat_while_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		rom_beat.wr |-> !dl_wait)
		else $error("ROM beat arrived while dl_wait was high");

endmodule

`default_nettype wire

/* rtl/rom_bus_arbiter.sv */
// ROM storage APB arbiter with fixed priority for the download writer over the system port
`default_nettype none

module rom_bus_arbiter (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire  bus_pkg::rom_apb_req_t dl_req,
	output bus_pkg::rom_apb_rsp_t       dl_rsp,
	input  wire  bus_pkg::rom_apb_req_t sys_req,
	output bus_pkg::rom_apb_rsp_t       sys_rsp,
	output bus_pkg::rom_apb_req_t       mem_req,
	input  wire  bus_pkg::rom_apb_rsp_t mem_rsp
);

	logic                  busy;      // Grant held
	logic                  grant_sys; // 0 download writer, 1 system port
	logic                  access_q;  // Storage access phase
	logic                  done;
	bus_pkg::rom_apb_req_t sel_req;

	assign done = busy && access_q && mem_rsp.pready;

	////////////////////////////////////////
	// Grant register
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy      <= 1'b0;
			grant_sys <= 1'b0;
			access_q  <= 1'b0;
		end else if (!busy) begin
			access_q <= 1'b0;
			if (dl_req.psel) begin // Writer wins a tie
				busy      <= 1'b1;
				grant_sys <= 1'b0;
			end else if (sys_req.psel) begin
				busy      <= 1'b1;
				grant_sys <= 1'b1;
			end
		end else if (done) begin
			busy     <= 1'b0; // Released after the completing cycle
			access_q <= 1'b0;
		end else begin
			access_q <= 1'b1;
		end
	end

	// Fields from the owner with phases regenerated here
	always_comb begin
		sel_req         = grant_sys ? sys_req : dl_req;
		mem_req         = sel_req;
		mem_req.psel    = busy;
		mem_req.penable = busy && access_q;
	end

	// Loser sees pready low and keeps waiting
	assign dl_rsp  = '{pready: done && !grant_sys, prdata: mem_rsp.prdata};
	assign sys_rsp = '{pready: done && grant_sys, prdata: mem_rsp.prdata};

	// Owner keeps its request up until the completing cycle
	a_grant_stable: assert property (@(posedge clk_sys) disable iff (RESET)
		(busy && !done) |=> (busy && $stable(grant_sys) &&
			(grant_sys ? sys_req.psel : dl_req.psel)))
		else $error("Grant changed or its owner left in mid-transfer");

	// Relies on the granted requester holding its fields
	a_req_stable: assert property (@(posedge clk_sys) disable iff (RESET)
		(mem_req.penable && !mem_rsp.pready) |=> $stable(mem_req))
		else $error("Storage request changed while pready low");

endmodule

`default_nettype wire

/* rtl/cart_loader_top.sv */
// Cartridge loader top with download decode, ROM writer, arbiter, header scanner, cheat loader
`default_nettype none

`include "cart_defines.svh"

module cart_loader_top (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire                         dl_active,
	input  wire                         dl_wr,
	input  wire  [7:0]                  dl_index,
	input  wire  [`CART_ADDR_W-1:0]     dl_addr,
	input  wire  [`CART_DATA_W-1:0]     dl_data,
	input  wire                         region_auto_off,
	input  wire                         region_from_ext,
	input  wire  [1:0]                  region_priority,
	input  wire  bus_pkg::rom_apb_req_t sys_req,
	output bus_pkg::rom_apb_rsp_t       sys_rsp,
	output bus_pkg::rom_apb_req_t       rom_req,
	input  wire  bus_pkg::rom_apb_rsp_t rom_rsp,
	output logic                        dl_wait,
	output cart_pkg::region_t           region_req,
	output logic                        region_set,
	output cart_pkg::cart_quirks_t      quirks,
	output cart_pkg::gun_cfg_t          gun_cfg,
	output logic [`CART_ADDR_W-1:0]     rom_size,
	output cart_pkg::cheat_code_t       cheat_code,
	output logic                        cheat_valid
);

	logic                  cheat_sel;
	cart_pkg::dl_word_t    rom_beat, cheat_beat;
	bus_pkg::rom_apb_req_t dl_req;
	bus_pkg::rom_apb_rsp_t dl_rsp;

	// Split the stream by index
	assign cheat_sel  = (dl_index == `CART_CHEAT_INDEX);
	assign rom_beat   = '{addr: dl_addr, data: dl_data, wr: dl_wr && dl_active && !cheat_sel};
	assign cheat_beat = '{addr: dl_addr, data: dl_data, wr: dl_wr && dl_active && cheat_sel};

	rom_download_writer u_writer (
		.clk_sys, .RESET, .dl_active, .rom_beat, .dl_wait, .rom_size,
		.apb_req (dl_req),
		.apb_rsp (dl_rsp)
	);

	rom_bus_arbiter u_arbiter (
		.clk_sys, .RESET, .dl_req, .dl_rsp, .sys_req, .sys_rsp,
		.mem_req (rom_req),
		.mem_rsp (rom_rsp)
	);

	cart_header_scan u_header_scan (
		.clk_sys, .RESET, .dl_active, .dl_index, .rom_beat,
		.region_auto_off, .region_from_ext, .region_priority,
		.region_req, .region_set, .quirks, .gun_cfg
	);

	cheat_code_loader u_cheat_loader (
		.clk_sys, .RESET, .cheat_beat, .cheat_code, .cheat_valid
	);

endmodule

`default_nettype wire

/* tb/tb_rom_memory.sv */
// APB ROM storage model with LFSR wait states and a backdoor read task
`default_nettype none

module tb_rom_memory (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire  bus_pkg::rom_apb_req_t req,
	output bus_pkg::rom_apb_rsp_t       rsp
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] mem [logic [23:0]]; // Sparse word storage
	logic [15:0] lfsr_state;
	logic [1:0]  wait_cnt;
	logic [1:0]  draw;
	logic [15:0] rd_q;
	logic [15:0] wr_word;

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb)
			s = s ^ 16'hB400;
		return s;
	endfunction

	assign rsp.pready = req.psel && req.penable && (wait_cnt == 2'd0);
	assign rsp.prdata = rd_q;

	always @(posedge clk_sys) begin
		if (RESET) begin
			wait_cnt   <= 2'd0;
			lfsr_state = 16'd64;
		end else if (req.psel && !req.penable) begin // Setup, pick wait states
			for (int k = 0; k < 2; k++) begin
				lfsr_state = lfsr_next(lfsr_state);
				draw = {draw[0], lfsr_state[0]};
			end
			wait_cnt <= draw;
			rd_q     <= mem.exists(req.paddr) ? mem[req.paddr] : 16'h0000;
		end else if (req.psel && req.penable) begin
			if (wait_cnt == 2'd0) begin
				if (req.pwrite) begin
					wr_word = mem.exists(req.paddr) ? mem[req.paddr] : 16'h0000;
					if (req.pstrb[0]) wr_word[7:0] = req.pwdata[7:0];
					if (req.pstrb[1]) wr_word[15:8] = req.pwdata[15:8];
					mem[req.paddr] = wr_word;
				end
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	// Backdoor for checking
	task automatic peek(input logic [23:0] a, output logic [15:0] d);
		d = mem.exists(a) ? mem[a] : 16'h0000;
	endtask

endmodule

`default_nettype wire

/* tb/tb_cart_loader.sv */
// Testbench top with clock, reset, download and system port stimulus, reference models, checks
`default_nettype none

`include "cart_defines.svh"

module tb_cart_loader;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 40;
	localparam int ROM_WORDS   = 64;
	localparam int SYS_OPS     = 8;
	localparam int HDR_COUNT   = 34;
	localparam int HDR_BEATS   = 9;
	localparam int CHEAT_WORDS = 8;
	localparam int TOTAL_BEATS = ROM_WORDS + 2 * SYS_OPS + HDR_COUNT * HDR_BEATS + CHEAT_WORDS;

	logic                    clk_sys = 1'b0;
	logic                    RESET;
	logic                    dl_active, dl_wr;
	logic [7:0]              dl_index;
	logic [`CART_ADDR_W-1:0] dl_addr;
	logic [`CART_DATA_W-1:0] dl_data;
	logic                    region_auto_off, region_from_ext;
	logic [1:0]              region_priority;
	bus_pkg::rom_apb_req_t   sys_req, rom_req;
	bus_pkg::rom_apb_rsp_t   sys_rsp, rom_rsp;
	logic                    dl_wait, region_set, cheat_valid;
	cart_pkg::region_t       region_req;
	cart_pkg::cart_quirks_t  quirks;
	cart_pkg::gun_cfg_t      gun_cfg;
	logic [`CART_ADDR_W-1:0] rom_size;
	cart_pkg::cheat_code_t   cheat_code;

	logic [15:0]      rng = 16'd64;
	logic [15:0]      rom_data [ROM_WORDS];
	logic [15:0]      sys_data [SYS_OPS];
	logic [7:0][15:0] cheat_words;
	logic [63:0]      ids [11] = '{"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ",
		"T-113016", "T-89016 ", "MK-1229 ", "T-35036 ", "T-95096-", "MK-1533 ", "T-12345 "};
	logic [15:0]      rgn0_cases [8] = '{16'h204A, 16'h2055, 16'h2045, 16'h2035,
		16'h2043, 16'h4520, 16'h2020, 16'h2020};
	logic [15:0]      rgn1_cases [8] = '{16'h2020, 16'h2020, 16'h2020, 16'h2020,
		16'h2020, 16'h2020, 16'h204A, 16'h2020};
	logic             in_cheat = 1'b0;
	int               cheat_pulses = 0;
	int               wait_in_cheat = 0;
	logic [15:0]      word;

	cart_loader_top DUT (
		.clk_sys, .RESET, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.region_auto_off, .region_from_ext, .region_priority, .sys_req, .sys_rsp,
		.rom_req, .rom_rsp, .dl_wait, .region_req, .region_set, .quirks, .gun_cfg,
		.rom_size, .cheat_code, .cheat_valid
	);

	tb_rom_memory u_mem (.clk_sys, .RESET, .req (rom_req), .rsp (rom_rsp));

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Reference models
	////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb)
			s = s ^ 16'hB400;
		return s;
	endfunction

	task automatic next_rand_word(output logic [15:0] w);
		for (int k = 0; k < 16; k++) begin
			rng = lfsr_step(rng);
			w = {w[14:0], rng[0]};
		end
	endtask

	function automatic logic [15:0] stored_word(input logic [15:0] w);
		return {w[7:0], w[15:8]}; // Storage holds bytes swapped
	endfunction

	// Header byte at a byte offset with the identifier at 0x183..0x18A
	function automatic logic [7:0] header_byte(input logic [63:0] id, input int b);
		if (b >= 'h183 && b <= 'h18A)
			return id[(63 - 8 * (b - 'h183)) -: 8];
		return " ";
	endfunction

	function automatic logic [15:0] id_word(input logic [63:0] id, input int a);
		return {header_byte(id, a + 1), header_byte(id, a)};
	endfunction

	function automatic logic [2:0] letter_flag(input logic [7:0] c); // {j, u, e}
		return {c == "J", c == "U", c == "E"};
	endfunction

	function automatic logic [2:0] header_flags(input logic [15:0] r0, input logic [15:0] r1);
		logic [2:0] f;
		logic [7:0] v;
		f = letter_flag(r0[7:0]);
		if (f == 3'b000) begin
			v = 8'h00;
			if (r0[7:0] >= "0" && r0[7:0] <= "9") v = r0[7:0] - "0";
			if (r0[7:0] >= "A" && r0[7:0] <= "F") v = r0[7:0] - "A" + 8'd10;
			f = {v[0], v[2], v[3]};
		end
		return f | letter_flag(r0[15:8]) | letter_flag(r1[7:0]);
	endfunction

	function automatic logic [1:0] expected_region(input logic [2:0] f, input logic [1:0] prio);
		logic [1:0] order [3];
		logic [2:0] have;
		have = 3'b000;
		case (prio)
			2'd0: order = '{2'd1, 2'd2, 2'd0};
			2'd1: order = '{2'd2, 2'd1, 2'd0};
			2'd2: order = '{2'd1, 2'd0, 2'd2};
			default: order = '{2'd0, 2'd1, 2'd2};
		endcase
		have[0] = f[2]; // JP
		have[1] = f[1]; // US
		have[2] = f[0]; // EU
		for (int k = 0; k < 3; k++)
			if (have[order[k]])
				return order[k];
		return order[0];
	endfunction

	function automatic logic [5:0] expected_quirks(input logic [63:0] id); // sram first
		case (id)
			"T-081276", "T-81406 ": return 6'b100000;
			"MK-1215 ", "G-4060  ": return 6'b010000;
			"T-113016": return 6'b001000;
			"T-89016 ": return 6'b000100;
			"MK-1229 ": return 6'b000010;
			"T-35036 ": return 6'b000001;
			default:    return 6'b000000;
		endcase
	endfunction

	function automatic logic [8:0] expected_gun(input logic [63:0] id);
		case (id)
			"T-95096-": return {1'b1, 8'd52};
			"MK-1533 ": return {1'b0, 8'd100};
			default:    return {1'b0, 8'd44};
		endcase
	endfunction

	function automatic logic [127:0] expected_cheat(input logic [7:0][15:0] w);
		return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
	endfunction

	////////////////////////////////////////
	// Checks and bus tasks
	////////////////////////////////////////

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %0h actual %0h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Host write entered at a falling edge
	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		while (dl_wait)
			@(negedge clk_sys);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic start_download(input logic [7:0] index);
		dl_index  = index;
		dl_active = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download;
		while (dl_wait)
			@(negedge clk_sys);
		dl_active = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic sys_access(input logic wr, input logic [23:0] a, input logic [15:0] wd,
		output logic [15:0] rd);
		sys_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: wd, pstrb: 2'b11};
		@(negedge clk_sys);
		sys_req.penable = 1'b1;
		while (!sys_rsp.pready) // Completes at the next rising edge
			@(negedge clk_sys);
		rd = sys_rsp.prdata;
		@(negedge clk_sys);
		sys_req = '0;
	endtask

	task automatic run_header(input logic [63:0] id, input logic [15:0] r0, input logic [15:0] r1,
		input logic [1:0] prio, input logic auto_off, input logic from_ext, input logic [7:0] index);
		region_priority = prio;
		region_auto_off = auto_off;
		region_from_ext = from_ext;
		start_download(index);
		check("quirks clear at new download", 6'd0, quirks);
		for (int a = 'h182; a <= 'h18A; a += 2)
			send_word(a, id_word(id, a));
		send_word(`CART_ID_CHECK, 16'h2020);
		check("quirks", expected_quirks(id), quirks);
		check("gun_cfg", expected_gun(id), gun_cfg);
		send_word(`CART_HDR_REGION0, r0);
		send_word(`CART_HDR_REGION1, r1);
		send_word(`CART_HDR_END, 16'h0000);
		if (auto_off) begin
			check("region_set with auto off", 1'b0, region_set);
		end else if (from_ext) begin
			check("region_set from index", |index, region_set);
			check("region_req from index", index[7:6], region_req);
		end else begin
			check("region_set", 1'b1, region_set);
			check("region_req", expected_region(header_flags(r0, r1), prio), region_req);
		end
		end_download;
		check("region_set after download", 1'b0, region_set);
	endtask

	// Cheat monitors sampled mid-cycle
	always @(negedge clk_sys) begin
		if (cheat_valid)
			cheat_pulses++;
		if (in_cheat && dl_wait)
			wait_in_cheat++;
	end

	initial begin
		#(TOTAL_BEATS * 20 * CLK_PERIOD);
		$display("Run hung, a handshake did not complete within the time limit");
		$display("Some tests failed");
		$fatal(1, "Watchdog timeout");
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		RESET = 1'b1;
		{dl_active, dl_wr, dl_index, dl_addr, dl_data} = '0;
		{region_auto_off, region_from_ext, region_priority} = '0;
		sys_req = '0;
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		check("dl_wait after reset", 1'b0, dl_wait);
		check("sys pready after reset", 1'b0, sys_rsp.pready);
		check("region_set after reset", 1'b0, region_set);
		check("cheat_valid after reset", 1'b0, cheat_valid);
		check("rom psel after reset", 1'b0, rom_req.psel);

		// ROM download with system port traffic alongside
		for (int i = 0; i < ROM_WORDS; i++)
			next_rand_word(rom_data[i]);
		for (int i = 0; i < SYS_OPS; i++)
			next_rand_word(sys_data[i]);
		start_download(8'h00);
		fork
			for (int i = 0; i < ROM_WORDS; i++)
				send_word(i * 2, rom_data[i]);
			for (int i = 0; i < SYS_OPS; i++) begin
				sys_access(1'b1, 24'h400000 + i, sys_data[i], word);
				sys_access(1'b0, 24'h400000 + i, 16'h0000, word);
				check("sys read back", sys_data[i], word);
			end
		join
		end_download;
		check("rom_size", (ROM_WORDS - 1) * 2, rom_size);
		for (int i = 0; i < ROM_WORDS; i++) begin
			u_mem.peek(i, word);
			check("storage word", stored_word(rom_data[i]), word);
		end

		// Region codes under each priority with identifiers cycled
		for (int c = 0; c < 8; c++)
			for (int p = 0; p < 4; p++)
				run_header(ids[(c * 4 + p) % 11], rgn0_cases[c], rgn1_cases[c], p, 1'b0,
					1'b0, 8'h00);

		// Region from the extension index
		run_header(ids[10], 16'h2020, 16'h2020, 2'd0, 1'b0, 1'b1, 8'h80);
		run_header(ids[10], 16'h2020, 16'h2020, 2'd0, 1'b1, 1'b1, 8'h80);

		// Cheat code
		for (int i = 0; i < CHEAT_WORDS; i++)
			next_rand_word(cheat_words[i]);
		cheat_pulses = 0;
		in_cheat = 1'b1;
		start_download(`CART_CHEAT_INDEX);
		for (int i = 0; i < CHEAT_WORDS; i++)
			send_word(i * 2, cheat_words[i]);
		end_download;
		in_cheat = 1'b0;
		check("cheat_valid pulses", 1, cheat_pulses);
		check("cheat_code", expected_cheat(cheat_words), cheat_code);
		check("dl_wait during cheat", 0, wait_in_cheat);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* cart_loader_top.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/cart_pkg.sv
rtl/cart_header_scan.sv
rtl/cheat_code_loader.sv
rtl/rom_download_writer.sv
rtl/rom_bus_arbiter.sv
rtl/cart_loader_top.sv
tb/tb_rom_memory.sv
tb/tb_cart_loader.sv

/* Bender.yml */
package:
  name: cart_loader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bus_pkg.sv
      - rtl/cart_pkg.sv
      - rtl/cart_header_scan.sv
      - rtl/cheat_code_loader.sv
      - rtl/rom_download_writer.sv
      - rtl/rom_bus_arbiter.sv
      - rtl/cart_loader_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/tb_rom_memory.sv
      - tb/tb_cart_loader.sv
